/* bench/chol_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module chol_asserts (
    input wire              clk,
    input wire              rst_n,
    input wire              busy_i,
    input wire              done_i,
    input wire              div_start_i,
    input wire              sqrt_start_i
);

    // done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done_i |=> !done_i)
        else $error("done_o stayed high for more than one cycle");

    a_busy_done: assert property (@(posedge clk) disable iff (!rst_n) !(busy_i && done_i))
        else $error("busy_o and done_o high together");

    // only one finish unit is started per element
    a_one_start: assert property (@(posedge clk) disable iff (!rst_n)
                                  !(div_start_i && sqrt_start_i))
        else $error("divider and sqrt started in the same cycle");

endmodule

`default_nettype wire

/* bench/tb_cholesky.sv */
`timescale 1ns/1ps
`default_nettype none

`include "chol_config.svh"

module tb_cholesky;

    localparam int N          = `CHOL_N;
    localparam int W          = `DATA_W;
    localparam int DONE_LIMIT = 2000;    // a full run takes a few hundred cycles

    typedef logic [N*N*W-1:0] mat_t;

    logic clk;
    logic rst_n;
    logic start_i;
    mat_t matrix_i;
    mat_t factor_o;
    logic busy_o;
    logic done_o;

    mat_t exp_q [$];    // one expected factor per accepted start
    mat_t exp_cur;
    int   runs;
    int   done_count;

    cholesky_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (start_i),
        .matrix_i (matrix_i),
        .factor_o (factor_o),
        .busy_o   (busy_o),
        .done_o   (done_o)
    );

    bind chol_ctrl chol_asserts u_asserts (
        .clk          (clk),
        .rst_n        (rst_n),
        .busy_i       (busy_o),
        .done_i       (done_o),
        .div_start_i  (div_start_o),
        .sqrt_start_i (sqrt_start_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic signed [31:0] got,
                             input logic signed [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic compare_factor(input mat_t exp);
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                check_val($sformatf("factor_o[%0d][%0d]", r, c),
                          $signed(factor_o[(r*N+c)*W +: W]), $signed(exp[(r*N+c)*W +: W]));
            end
        end
    endtask

    function automatic longint elem(input mat_t m, input int r, input int c);
        logic signed [W-1:0] v;
        v = m[(r*N+c)*W +: W];
        return longint'(v);
    endfunction

    // keep the low DATA_W bits as a signed value
    function automatic longint wrap_q(input longint v);
        logic signed [W-1:0] t;
        t = v[W-1:0];
        return longint'(t);
    endfunction

    function automatic longint isqrt(input longint x);
        longint r;
        r = 0;
        for (int b = W - 1; b >= 0; b--) begin
            if ((r + (64'd1 << b)) * (r + (64'd1 << b)) <= x) r = r + (64'd1 << b);
        end
        return r;
    endfunction

    // row-by-row Cholesky in Q8.8 with the truncation rules of the datapath
    function automatic mat_t chol_ref(input mat_t a);
        longint l [N][N];
        longint acc;
        longint res;
        longint mag;
        longint q;
        mat_t   f;
        f = '0;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) l[r][c] = 0;
        end
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j <= i; j++) begin
                acc = elem(a, i, j) * (64'd1 << `FRAC_W);    // product scale
                for (int k = 0; k < j; k++) begin
                    acc = acc - l[i][k] * l[j][k];
                end
                res = wrap_q(acc >>> `FRAC_W);               // floor
                if (i == j) begin
                    q = (res > 0) ? isqrt(res * (64'd1 << `FRAC_W)) : 0;
                end else begin
                    mag = (res < 0) ? -res : res;
                    // zero divisor gives an all-ones quotient
                    q = (l[j][j] == 0) ? 64'hffff :
                        ((mag * (64'd1 << `FRAC_W)) / l[j][j]) & 64'hffff;
                    q = wrap_q((res < 0) ? -q : q);          // truncated toward zero
                end
                l[i][j] = q;
                f[(i*N+j)*W +: W] = q[W-1:0];
            end
        end
        return f;
    endfunction

    // B times B-transpose plus a diagonal boost, entries of B within +-2.0
    task automatic make_spd(output mat_t m);
        int     b [N][N];
        longint s;
        m = '0;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) b[r][c] = int'($urandom % 1025) - 512;
        end
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c <= r; c++) begin
                s = 0;
                for (int k = 0; k < N; k++) s = s + b[r][k] * b[c][k];
                s = s >>> `FRAC_W;
                if (r == c) s = s + 256 + int'($urandom % 769);   // 1.0 to 4.0
                m[(r*N+c)*W +: W] = s[W-1:0];
                m[(c*N+r)*W +: W] = s[W-1:0];
            end
        end
    endtask

    // called on a rising edge, returns two edges later with busy checked
    task automatic start_run(input mat_t m, input mat_t exp);
        exp_q.push_back(exp);
        runs++;
        start_i  <= 1'b1;
        matrix_i <= m;
        @(posedge clk);
        start_i <= 1'b0;
        @(posedge clk);
        check_val("busy_o", busy_o, 1);
    endtask

    // returns on the edge where done_o is seen
    task automatic wait_done(input string what);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!done_o && cycles < DONE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!done_o) report_failure($sformatf("timeout: no done_o for the %s run", what));
    endtask

    task automatic quiet_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            if (done_o) report_failure("done_o pulsed with no run in progress");
        end
    endtask

    // compare on every done pulse
    always @(posedge clk) begin
        if (rst_n && done_o) begin
            if (exp_q.size() == 0) begin
                report_failure("done_o pulsed with no expected result pending");
            end else begin
                exp_cur = exp_q.pop_front();
                compare_factor(exp_cur);
                done_count++;
            end
        end
    end

    initial begin
        mat_t m;
        mat_t m2;
        mat_t diag_exp;
        void'($urandom(32'h1f9e635a));
        rst_n      = 1'b0;
        start_i    = 1'b0;
        matrix_i   = '0;
        runs       = 0;
        done_count = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_val("busy_o", busy_o, 0);
        check_val("done_o", done_o, 0);
        compare_factor('0);

        // diag(16, 4, 9, 1) gives diag(4, 2, 3, 1)
        m        = '0;
        diag_exp = '0;
        m[(0*N+0)*W +: W]        = 16'h1000;
        m[(1*N+1)*W +: W]        = 16'h0400;
        m[(2*N+2)*W +: W]        = 16'h0900;
        m[(3*N+3)*W +: W]        = 16'h0100;
        diag_exp[(0*N+0)*W +: W] = 16'h0400;
        diag_exp[(1*N+1)*W +: W] = 16'h0200;
        diag_exp[(2*N+2)*W +: W] = 16'h0300;
        diag_exp[(3*N+3)*W +: W] = 16'h0100;
        start_run(m, diag_exp);
        wait_done("diagonal matrix");

        repeat (20) begin
            make_spd(m);
            start_run(m, chol_ref(m));
            wait_done("random matrix");
        end

        // second start while busy carries another matrix and must be ignored
        make_spd(m);
        make_spd(m2);
        start_run(m, chol_ref(m));
        repeat (5) @(posedge clk);
        check_val("busy_o", busy_o, 1);
        start_i  <= 1'b1;
        matrix_i <= m2;
        @(posedge clk);
        start_i <= 1'b0;
        wait_done("start while busy");
        quiet_cycles(400);
        check_val("done count", done_count, runs);

        // next start on the cycle after done
        make_spd(m);
        start_run(m, chol_ref(m));
        repeat (3) begin
            wait_done("back-to-back");
            make_spd(m);
            start_run(m, chol_ref(m));
        end
        wait_done("last back-to-back");
        quiet_cycles(50);
        check_val("done count", done_count, runs);

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* source/chol_config.svh */
`ifndef CHOL_CONFIG_SVH
`define CHOL_CONFIG_SVH

// matrix dimension
`define CHOL_N 4

// element format is signed Q8.8
`define DATA_W 16
`define FRAC_W 8

// full-precision sums of Q16.16 products with headroom
`define ACC_W 36

// row, column and k indices
`define IDX_W 2

`endif

/* source/chol_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "chol_config.svh"

module chol_ctrl import chol_pkg::*; (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        start_i,
    output logic                       busy_o,
    output logic                       done_o,
    output logic                       capture_o,
    output mac_op_e                    mac_op_o,
    output logic                       div_start_o,
    input  wire                        div_done_i,
    input  wire signed [`DATA_W-1:0]   quot_i,
    output logic                       sqrt_start_o,
    input  wire                        sqrt_done_i,
    input  wire signed [`DATA_W-1:0]   root_i,
    store_if.ctrl                      st
);

    ctrl_state_e         state_q;
    logic [`IDX_W-1:0]   i_q;        // row
    logic [`IDX_W-1:0]   j_q;        // column, never above i
    logic [`IDX_W-1:0]   k_q;
    logic                init_q;     // next issue slot is MAC_INIT
    logic                drain_q;
    logic                on_diag;
    logic                last_elem;
    logic                unit_done;

    assign on_diag   = (i_q == j_q);
    assign last_elem = on_diag && (i_q == `IDX_W'(`CHOL_N - 1));
    assign unit_done = on_diag ? sqrt_done_i : div_done_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            i_q     <= '0;
            j_q     <= '0;
            k_q     <= '0;
            init_q  <= 1'b0;
            drain_q <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        i_q     <= '0;
                        j_q     <= '0;
                        k_q     <= '0;
                        init_q  <= 1'b1;
                        state_q <= MAC_ISSUE;
                    end
                end
                MAC_ISSUE: begin
                    if (init_q) begin
                        init_q <= 1'b0;
                        if (j_q == '0) begin
                            state_q <= MAC_DRAIN;    // first column has no products
                        end
                    end else if (k_q == j_q - 1'b1) begin
                        state_q <= MAC_DRAIN;
                    end else begin
                        k_q <= k_q + 1'b1;
                    end
                end
                MAC_DRAIN: begin
                    drain_q <= ~drain_q;
                    if (drain_q) begin
                        state_q <= FINISH_START;
                    end
                end
                FINISH_START: state_q <= FINISH_WAIT;
                FINISH_WAIT: begin
                    if (unit_done) begin
                        state_q <= WRITE_BACK;
                    end
                end
                WRITE_BACK: begin
                    k_q     <= '0;
                    init_q  <= 1'b1;
                    state_q <= MAC_ISSUE;
                    if (last_elem) begin
                        init_q  <= 1'b0;
                        done_o  <= 1'b1;
                        state_q <= IDLE;
                    end else if (on_diag) begin
                        i_q <= i_q + 1'b1;   // row ends on the diagonal
                        j_q <= '0;
                    end else begin
                        j_q <= j_q + 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign busy_o       = (state_q != IDLE);
    assign capture_o    = (state_q == IDLE) && start_i;
    assign div_start_o  = (state_q == FINISH_START) && !on_diag;
    assign sqrt_start_o = (state_q == FINISH_START) && on_diag;
    assign mac_op_o     = (state_q != MAC_ISSUE) ? MAC_NOP : (init_q ? MAC_INIT : MAC_SUB);

    // store addressing follows the element being worked on
    assign st.row     = i_q;
    assign st.col     = j_q;
    assign st.k       = k_q;
    assign st.wr_en   = (state_q == WRITE_BACK);
    assign st.wr_data = on_diag ? root_i : quot_i;   // both units hold their result

endmodule

`default_nettype wire

/* source/chol_pkg.sv */
`default_nettype none

package chol_pkg;

    // controller sequencing, one element at a time
    typedef enum logic [2:0] {
        IDLE,           // waiting for start
        MAC_ISSUE,      // init then one subtract per k
        MAC_DRAIN,      // two cycles for the MAC pipeline
        FINISH_START,   // kick divider or sqrt
        FINISH_WAIT,
        WRITE_BACK      // store l_ij and step the indices
    } ctrl_state_e;

    // MAC opcodes
    typedef enum logic [1:0] {
        MAC_NOP,        // hold accumulator
        MAC_INIT,       // load a_ij aligned to the product scale
        MAC_SUB         // subtract l_ik * l_jk
    } mac_op_e;

endpackage

`default_nettype wire

/* source/cholesky_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "chol_config.svh"

module cholesky_top import chol_pkg::*; (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  start_i,
    input  wire  [`CHOL_N*`CHOL_N*`DATA_W-1:0]   matrix_i,
    output logic [`CHOL_N*`CHOL_N*`DATA_W-1:0]   factor_o,
    output logic                                 busy_o,
    output logic                                 done_o
);

    logic                       capture;
    mac_op_e                    mac_op;
    logic signed [`DATA_W-1:0]  residual;    // numerator for both finish units
    logic                       div_start;
    logic                       div_done;
    logic signed [`DATA_W-1:0]  quot;
    logic                       sqrt_start;
    logic                       sqrt_done;
    logic signed [`DATA_W-1:0]  root;

    store_if u_store_if ();

    matrix_store u_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .capture_i (capture),
        .matrix_i  (matrix_i),
        .factor_o  (factor_o),
        .st        (u_store_if)
    );

    mac_unit u_mac (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_i       (mac_op),
        .st         (u_store_if),
        .residual_o (residual)
    );

    seq_divider u_div (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (div_start),
        .num_i   (residual),
        .st      (u_store_if),
        .done_o  (div_done),
        .quot_o  (quot)
    );

    seq_sqrt u_sqrt (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (sqrt_start),
        .num_i   (residual),
        .done_o  (sqrt_done),
        .root_o  (root)
    );

    chol_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .capture_o    (capture),
        .mac_op_o     (mac_op),
        .div_start_o  (div_start),
        .div_done_i   (div_done),
        .quot_i       (quot),
        .sqrt_start_o (sqrt_start),
        .sqrt_done_i  (sqrt_done),
        .root_i       (root),
        .st           (u_store_if)
    );

endmodule

`default_nettype wire

/* source/mac_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "chol_config.svh"

module mac_unit import chol_pkg::*; (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire mac_op_e               op_i,
    store_if.mac                       st,
    output logic signed [`DATA_W-1:0]  residual_o
);

    mac_op_e                       op_q;
    logic signed [2*`DATA_W-1:0]   prod_q;     // Q16.16
    logic signed [`DATA_W-1:0]     aij_q;
    logic signed [`ACC_W-1:0]      acc_q;
    logic signed [`ACC_W-1:0]      prod_ext;
    logic signed [`ACC_W-1:0]      aij_ext;
    logic signed [`ACC_W-1:0]      acc_shr;

    // stage one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q <= MAC_NOP;
        end else begin
            op_q <= op_i;
        end
    end

    always_ff @(posedge clk) begin
        prod_q <= st.l_ik * st.l_jk;   // full width signed product
        aij_q  <= st.a_ij;
    end

    assign prod_ext = prod_q;          // sign extend
    assign aij_ext  = aij_q;

    // stage two, accumulator kept at product scale
    always_ff @(posedge clk) begin
        case (op_q)
            MAC_INIT: acc_q <= aij_ext <<< `FRAC_W;
            MAC_SUB:  acc_q <= acc_q - prod_ext;
            default:  acc_q <= acc_q;
        endcase
    end

    // floor back to Q8.8
    assign acc_shr    = acc_q >>> `FRAC_W;
    assign residual_o = acc_shr[`DATA_W-1:0];

endmodule

`default_nettype wire

/* source/matrix_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "chol_config.svh"

module matrix_store (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  capture_i,  // accepted start
    input  wire  [`CHOL_N*`CHOL_N*`DATA_W-1:0]   matrix_i,   // row-major, element 0 at lsb
    output logic [`CHOL_N*`CHOL_N*`DATA_W-1:0]   factor_o,
    store_if.store                               st
);

    logic [`DATA_W-1:0] a_q [`CHOL_N][`CHOL_N];   // lower triangle of A
    logic [`DATA_W-1:0] l_q [`CHOL_N][`CHOL_N];   // factor under construction

    // only the lower triangle of A is ever read, upper half kept at zero
    always_ff @(posedge clk) begin
        if (capture_i) begin
            for (int r = 0; r < `CHOL_N; r++) begin
                for (int c = 0; c < `CHOL_N; c++) begin
                    a_q[r][c] <= (c <= r) ? matrix_i[(r*`CHOL_N+c)*`DATA_W +: `DATA_W] : '0;
                end
            end
        end
    end

    // L is visible on factor_o, so it starts from zero after reset and capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `CHOL_N; r++) begin
                for (int c = 0; c < `CHOL_N; c++) begin
                    l_q[r][c] <= '0;
                end
            end
        end else if (capture_i) begin
            for (int r = 0; r < `CHOL_N; r++) begin
                for (int c = 0; c < `CHOL_N; c++) begin
                    l_q[r][c] <= '0;
                end
            end
        end else if (st.wr_en) begin
            l_q[st.row][st.col] <= st.wr_data;
        end
    end

    // indexed reads for the MAC and the divider
    assign st.a_ij = a_q[st.row][st.col];
    assign st.l_ik = l_q[st.row][st.k];
    assign st.l_jk = l_q[st.col][st.k];    // same as l_ik on the diagonal
    assign st.l_jj = l_q[st.col][st.col];

    always_comb begin
        for (int r = 0; r < `CHOL_N; r++) begin
            for (int c = 0; c < `CHOL_N; c++) begin
                // upper triangle is always zero
                factor_o[(r*`CHOL_N+c)*`DATA_W +: `DATA_W] = (c <= r) ? l_q[r][c] : '0;
            end
        end
    end

endmodule

`default_nettype wire

/* source/seq_divider.sv */
`timescale 1ns/1ps
`default_nettype none

`include "chol_config.svh"

module seq_divider (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        start_i,
    input  wire signed [`DATA_W-1:0]   num_i,
    store_if.div                       st,
    output logic                       done_o,
    output logic signed [`DATA_W-1:0]  quot_o
);

    localparam int DVD_W = `DATA_W + `FRAC_W;     // one quotient bit per cycle
    localparam int CNT_W = $clog2(DVD_W + 1);

    logic [CNT_W-1:0]    cnt_q;
    logic [DVD_W-1:0]    dvd_q;      // dividend shifts out at the top, quotient in at the bottom
    logic [`DATA_W-1:0]  rem_q;
    logic [`DATA_W-1:0]  den_q;
    logic                neg_q;
    logic [`DATA_W:0]    num_ext;
    logic [`DATA_W:0]    num_mag;
    logic [`DATA_W:0]    rem_try;
    logic [`DATA_W:0]    rem_sub;
    logic                q_bit;
    logic [`DATA_W-1:0]  rem_next;
    logic [DVD_W-1:0]    q_next;

    // 17 bits so that -32768 has a magnitude
    assign num_ext = {num_i[`DATA_W-1], num_i};
    assign num_mag = num_i[`DATA_W-1] ? -num_ext : num_ext;

    // restoring step
    assign rem_try  = {rem_q, dvd_q[DVD_W-1]};
    assign rem_sub  = rem_try - {1'b0, den_q};
    assign q_bit    = (rem_try >= {1'b0, den_q});
    assign rem_next = q_bit ? rem_sub[`DATA_W-1:0] : rem_try[`DATA_W-1:0];
    assign q_next   = {dvd_q[DVD_W-2:0], q_bit};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q  <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= (cnt_q == CNT_W'(1));       // last step
            if (start_i) begin
                cnt_q <= CNT_W'(DVD_W);
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            dvd_q <= {num_mag[`DATA_W-1:0], {`FRAC_W{1'b0}}};
            rem_q <= '0;
            den_q <= st.l_jj;                     // l_jj is never negative
            neg_q <= num_i[`DATA_W-1];
        end else if (cnt_q != '0) begin
            dvd_q <= q_next;
            rem_q <= rem_next;
            if (cnt_q == CNT_W'(1)) begin
                quot_o <= neg_q ? -q_next[`DATA_W-1:0] : q_next[`DATA_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* source/seq_sqrt.sv */
`timescale 1ns/1ps
`default_nettype none

`include "chol_config.svh"

module seq_sqrt (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        start_i,
    input  wire signed [`DATA_W-1:0]   num_i,
    output logic                       done_o,
    output logic signed [`DATA_W-1:0]  root_o
);

    localparam int RAD_W = 2 * `DATA_W;      // two radicand bits per root bit
    localparam int REM_W = `DATA_W + 2;
    localparam int CNT_W = $clog2(`DATA_W + 1);

    logic [CNT_W-1:0]    cnt_q;
    logic [RAD_W-1:0]    rad_q;
    logic [REM_W-1:0]    rem_q;
    logic [`DATA_W-1:0]  root_q;
    logic [REM_W+1:0]    rem_try;
    logic [REM_W+1:0]    trial;
    logic [REM_W+1:0]    rem_sub;
    logic                bit_ok;
    logic [`DATA_W-1:0]  root_next;

    assign rem_try   = {rem_q, rad_q[RAD_W-1 -: 2]};
    assign trial     = {2'b00, root_q, 2'b01};     // 4*root + 1
    assign rem_sub   = rem_try - trial;
    assign bit_ok    = (rem_try >= trial);
    assign root_next = {root_q[`DATA_W-2:0], bit_ok};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q  <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= (cnt_q == CNT_W'(1));
            if (start_i) begin
                cnt_q <= CNT_W'(`DATA_W);
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            // a zero radicand gives a zero root, which covers num <= 0
            rad_q  <= (num_i > 0) ?
                      {{(`DATA_W-`FRAC_W){1'b0}}, num_i, {`FRAC_W{1'b0}}} : '0;
            rem_q  <= '0;
            root_q <= '0;
        end else if (cnt_q != '0) begin
            rad_q  <= rad_q << 2;
            rem_q  <= bit_ok ? rem_sub[REM_W-1:0] : rem_try[REM_W-1:0];
            root_q <= root_next;
            if (cnt_q == CNT_W'(1)) begin
                root_o <= root_next;
            end
        end
    end

endmodule

`default_nettype wire

/* source/store_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "chol_config.svh"

interface store_if;

    // indices, all from the controller
    logic [`IDX_W-1:0]         row;        // i
    logic [`IDX_W-1:0]         col;        // j
    logic [`IDX_W-1:0]         k;

    // combinational read data from the store
    logic signed [`DATA_W-1:0] a_ij;
    logic signed [`DATA_W-1:0] l_ik;
    logic signed [`DATA_W-1:0] l_jk;
    logic signed [`DATA_W-1:0] l_jj;       // divisor for off-diagonal elements

    // write of l at (row, col)
    logic                      wr_en;
    logic signed [`DATA_W-1:0] wr_data;

    modport store (
        input  row, col, k, wr_en, wr_data,
        output a_ij, l_ik, l_jk, l_jj
    );

    modport ctrl (
        output row, col, k, wr_en, wr_data
    );

    modport mac (
        input  a_ij, l_ik, l_jk
    );

    modport div (
        input  l_jj
    );

endinterface

`default_nettype wire

/* sources.f */
+incdir+source
source/chol_pkg.sv
source/store_if.sv
source/matrix_store.sv
source/mac_unit.sv
source/seq_divider.sv
source/seq_sqrt.sv
source/chol_ctrl.sv
source/cholesky_top.sv
bench/chol_asserts.sv
bench/tb_cholesky.sv
